// ==== files.f ====
+incdir+test
logic/idct_pkg.sv
logic/idct_pass.sv
logic/transpose_buffer.sv
logic/idct_2d.sv
test/idct_tb.sv

// ==== logic/idct_2d.sv ====
// top level of the streaming 8x8 inverse DCT, takes coefficient rows and returns output vectors
`timescale 1ns/1ps

module idct_2d #(
        parameter int COL_SHIFT = idct_pkg::COL_SHIFT,
        parameter int ROW_SHIFT = idct_pkg::ROW_SHIFT
) (
        input  logic               clk,
        input  logic               reset,
        input  logic               in_valid,
        input  idct_pkg::sample_t  in_row [8],
        output logic               out_valid,
        output idct_pkg::sample_t  out_row [8]
);
        import idct_pkg::*;

        logic    col_valid;
        sample_t col_row [8];
        logic    tr_valid;
        sample_t tr_row [8];

        // first pass over the incoming rows
        idct_pass #(
                .SHIFT(COL_SHIFT)
        ) col_pass (
                .clk(clk),
                .reset(reset),
                .in_valid(in_valid),
                .in_row(in_row),
                .out_valid(col_valid),
                .out_row(col_row)
        );

        transpose_buffer transpose (
                .clk(clk),
                .reset(reset),
                .in_valid(col_valid),
                .in_row(col_row),
                .out_valid(tr_valid),
                .out_row(tr_row)
        );

        // second pass over the columns
        idct_pass #(
                .SHIFT(ROW_SHIFT)
        ) row_pass (
                .clk(clk),
                .reset(reset),
                .in_valid(tr_valid),
                .in_row(tr_row),
                .out_valid(out_valid),
                .out_row(out_row)
        );

endmodule

// ==== logic/idct_pass.sv ====
// one-dimensional 8-point inverse DCT pass, instantiated for rows and for columns in idct_2d
`timescale 1ns/1ps

module idct_pass #(
        parameter int SHIFT = idct_pkg::COL_SHIFT
) (
        input  logic               clk,
        input  logic               reset,
        input  logic               in_valid,
        input  idct_pkg::sample_t  in_row [8],
        output logic               out_valid,
        output idct_pkg::sample_t  out_row [8]
);
        import idct_pkg::*;

        localparam acc_t ROUND = acc_t'(1) <<< (SHIFT - 1);  // half of the shift step

        acc_t prod_q [8][8];    // [k][n]
        logic valid_q;
        acc_t sum_c [8];

        always_ff @(posedge clk or posedge reset) begin
                if (reset) begin
                        valid_q <= 1'b0;
                        out_valid <= 1'b0;
                end else begin
                        valid_q <= in_valid;
                        out_valid <= valid_q;
                end
        end

        // stage one, all 64 products
        always_ff @(posedge clk) begin
                if (in_valid) begin
                        for (int k = 0; k < 8; k++) begin
                                for (int n = 0; n < 8; n++) begin
                                        prod_q[k][n] <= acc_t'(in_row[k]) * acc_t'(IDCT_COEF[k][n]);
                                end
                        end
                end
        end

        always_comb begin
                for (int n = 0; n < 8; n++) begin
                        sum_c[n] = ROUND;
                        for (int k = 0; k < 8; k++) begin
                                sum_c[n] = sum_c[n] + prod_q[k][n];
                        end
                end
        end

        // stage two, floor shift then truncate
        always_ff @(posedge clk) begin
                if (valid_q) begin
                        for (int n = 0; n < 8; n++) begin
                                out_row[n] <= sample_t'(sum_c[n] >>> SHIFT);
                        end
                end
        end

        // a row accepted with no reset in between leaves exactly two edges later
        assert property (@(posedge clk) disable iff (reset)
                !$past(reset) && !$past(reset, 2) |-> out_valid == $past(in_valid, 2))
                else $error("idct_pass: out_valid does not follow in_valid by two cycles");

endmodule

// ==== logic/idct_pkg.sv ====
// shared types, cosine table and default rounding shifts, imported by every idct module
package idct_pkg;

        localparam int SAMPLE_W = 25;
        localparam int ACC_W = 36;      // eight 25x8 bit products summed

        typedef logic signed [SAMPLE_W-1:0] sample_t;
        typedef logic signed [ACC_W-1:0] acc_t;
        typedef logic signed [7:0] coef_t;

        localparam int COL_SHIFT = 7;   // first pass
        localparam int ROW_SHIFT = 12;  // second pass

        // integer cosine matrix, first index is frequency k, second is position n
        localparam coef_t IDCT_COEF [8][8] = '{
                '{8'sd64,  8'sd64,  8'sd64,  8'sd64,  8'sd64,  8'sd64,  8'sd64,  8'sd64},
                '{8'sd89,  8'sd75,  8'sd50,  8'sd18, -8'sd18, -8'sd50, -8'sd75, -8'sd89},
                '{8'sd83,  8'sd36, -8'sd36, -8'sd83, -8'sd83, -8'sd36,  8'sd36,  8'sd83},
                '{8'sd75, -8'sd18, -8'sd89, -8'sd50,  8'sd50,  8'sd89,  8'sd18, -8'sd75},
                '{8'sd64, -8'sd64, -8'sd64,  8'sd64,  8'sd64, -8'sd64, -8'sd64,  8'sd64},
                '{8'sd50, -8'sd89,  8'sd18,  8'sd75, -8'sd75, -8'sd18,  8'sd89, -8'sd50},
                '{8'sd36, -8'sd83,  8'sd83, -8'sd36, -8'sd36,  8'sd83, -8'sd83,  8'sd36},
                '{8'sd18, -8'sd50,  8'sd75, -8'sd89,  8'sd89, -8'sd75,  8'sd50, -8'sd18}
        };

endpackage

// ==== logic/transpose_buffer.sv ====
// ping-pong 8x8 buffer between the idct passes, takes rows and hands out columns
`timescale 1ns/1ps

module transpose_buffer (
        input  logic               clk,
        input  logic               reset,
        input  logic               in_valid,
        input  idct_pkg::sample_t  in_row [8],
        output logic               out_valid,
        output idct_pkg::sample_t  out_row [8]
);
        import idct_pkg::*;

        typedef enum logic {IDLE, READ} read_state_t;

        sample_t     bank [2][8][8];    // [bank][row][col]
        logic        wr_bank;
        logic [2:0]  row_cnt;
        logic [1:0]  full;
        logic [1:0]  full_set;
        logic [1:0]  full_clr;
        logic [1:0]  ready;
        logic        fill_done;
        logic        rd_last;
        read_state_t state;
        logic        rd_bank;
        logic [2:0]  col_cnt;

        assign fill_done = in_valid && (row_cnt == 3'd7);
        assign rd_last = (state == READ) && (col_cnt == 3'd7);
        assign full_set = fill_done ? (2'b01 << wr_bank) : 2'b00;
        assign full_clr = rd_last ? (2'b01 << rd_bank) : 2'b00;
        assign ready = full | full_set;         // full now or filling at this edge

        always_ff @(posedge clk) begin
                if (in_valid) begin
                        for (int c = 0; c < 8; c++) begin
                                bank[wr_bank][row_cnt][c] <= in_row[c];
                        end
                end
        end

        always_ff @(posedge clk or posedge reset) begin
                if (reset) begin
                        wr_bank <= 1'b0;
                        row_cnt <= 3'd0;
                end else if (in_valid) begin
                        row_cnt <= row_cnt + 3'd1;      // wraps after row 7
                        if (row_cnt == 3'd7) begin
                                wr_bank <= ~wr_bank;
                        end
                end
        end

        always_ff @(posedge clk or posedge reset) begin
                if (reset) begin
                        full <= 2'b00;
                end else begin
                        full <= (full | full_set) & ~full_clr;
                end
        end

        always_ff @(posedge clk or posedge reset) begin
                if (reset) begin
                        state <= IDLE;
                        rd_bank <= 1'b0;
                        col_cnt <= 3'd0;
                end else begin
                        case (state)
                        IDLE: begin
                                if (ready[rd_bank]) begin
                                        state <= READ;
                                end
                        end
                        READ: begin
                                col_cnt <= col_cnt + 3'd1;
                                if (rd_last) begin
                                        rd_bank <= ~rd_bank;
                                        if (!ready[~rd_bank]) begin   // next block not done yet
                                                state <= IDLE;
                                        end
                                end
                        end
                        default: begin
                                state <= IDLE;
                        end
                        endcase
                end
        end

        assign out_valid = (state == READ);

        always_comb begin
                for (int r = 0; r < 8; r++) begin
                        out_row[r] = bank[rd_bank][r][col_cnt];
                end
        end

        // the source has no back-pressure, so a row must never land in a bank still in use
        assert property (@(posedge clk) disable iff (reset) in_valid |-> !full[wr_bank])
                else $error("transpose_buffer: overrun, row written into a busy bank");

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the idct testbench with Verilator, exit status follows the result

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module idct_tb -f files.f \
        -o idct_sim > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
        cat "$BUILD_LOG"
        echo "verilator build failed with status $status"
        exit 1
fi

./obj_dir/idct_sim > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
        echo "simulation exited with status $status"
        exit 1
fi

if grep -q "TEST RESULT: FAIL" "$SIM_LOG"; then
        exit 1
fi

exit 0

// ==== test/idct_model.svh ====
// expected-value model and random source for the idct testbench, included inside idct_tb
`ifndef IDCT_MODEL_SVH
`define IDCT_MODEL_SVH

        int unsigned lcg_state = 32'd73386;
        sample_t     expect_q [$];      // flattened expected vectors, eight samples each

        function automatic int unsigned next_rand();
                lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
                return lcg_state >> 8;          // low bits of an lcg are weak
        endfunction

        // coefficient in -4095 .. 4095
        function automatic sample_t rand_coef();
                int value;
                value = int'(next_rand() % 32'd8191) - 4095;
                return sample_t'(value);
        endfunction

        // output n of one 8-point inverse transform with rounding and floor shift
        function automatic sample_t pass_value(input sample_t v [8], input int n, input int shift);
                acc_t sum;
                sum = acc_t'(2 ** (shift - 1));
                for (int k = 0; k < 8; k++) begin
                        sum = sum + acc_t'(v[k]) * acc_t'(IDCT_COEF[k][n]);
                end
                return sample_t'(sum >>> shift);
        endfunction

        // rows first, then columns of the intermediate block, queued in output order
        task automatic model_block(input sample_t b [8][8]);
                sample_t u [8][8];
                sample_t vec [8];
                for (int r = 0; r < 8; r++) begin
                        for (int c = 0; c < 8; c++) begin
                                vec[c] = b[r][c];
                        end
                        for (int n = 0; n < 8; n++) begin
                                u[r][n] = pass_value(vec, n, COL_SHIFT);
                        end
                end
                for (int j = 0; j < 8; j++) begin
                        for (int r = 0; r < 8; r++) begin
                                vec[r] = u[r][j];       // column j
                        end
                        for (int n = 0; n < 8; n++) begin
                                expect_q.push_back(pass_value(vec, n, ROW_SHIFT));
                        end
                end
        endtask

`endif

// ==== test/idct_tb.sv ====
// directed testbench for idct_2d, drives coefficient blocks and compares output vectors
`timescale 1ns/1ps

module idct_tb;
        import idct_pkg::*;

        `include "idct_model.svh"

        logic    clk;
        logic    reset;
        logic    in_valid;
        sample_t in_row [8];
        logic    out_valid;
        sample_t out_row [8];

        sample_t got_q [$];             // flattened received vectors
        sample_t blk [8][8];            // block being sent

        idct_2d DUT (
                .clk(clk),
                .reset(reset),
                .in_valid(in_valid),
                .in_row(in_row),
                .out_valid(out_valid),
                .out_row(out_row)
        );

        initial begin
                clk = 1'b0;
                forever #4 clk = ~clk;
        end

        // outputs are registered, so the falling edge sees them settled
        always @(negedge clk) begin
                if (out_valid) begin
                        for (int i = 0; i < 8; i++) begin
                                got_q.push_back(out_row[i]);
                        end
                end
        end

        task automatic fail_run(input string msg);
                $display("%s", msg);
                $display("TEST RESULT: FAIL");
                $fatal(1, "simulation stopped at first error");
        endtask

        task automatic check_sample(input string test, input sample_t exp, input sample_t act);
                if (act !== exp) begin
                        fail_run($sformatf("[FAIL] %s expected %0d actual %0d", test, exp, act));
                end
        endtask

        task automatic check_count(input string test, input int exp, input int act);
                if (act != exp) begin
                        fail_run($sformatf("[FAIL] %s vector count expected %0d actual %0d",
                                test, exp, act));
                end
        endtask

        task automatic clear_block();
                for (int r = 0; r < 8; r++) begin
                        for (int c = 0; c < 8; c++) begin
                                blk[r][c] = '0;
                        end
                end
        endtask

        task automatic random_block();
                for (int r = 0; r < 8; r++) begin
                        for (int c = 0; c < 8; c++) begin
                                blk[r][c] = rand_coef();
                        end
                end
        endtask

        // starts and ends on a falling edge
        task automatic send_rows(input int count, input int max_gap);
                int gap;
                for (int r = 0; r < count; r++) begin
                        for (int c = 0; c < 8; c++) begin
                                in_row[c] = blk[r][c];
                        end
                        in_valid = 1'b1;
                        @(negedge clk);
                        in_valid = 1'b0;
                        gap = (max_gap > 0) ? int'(next_rand() % (max_gap + 1)) : 0;
                        repeat (gap) @(negedge clk);
                end
        endtask

        task automatic send_block(input int max_gap);
                model_block(blk);
                send_rows(8, max_gap);
        endtask

        task automatic wait_vectors(input string test, input int count);
                int cycles;
                cycles = 0;
                while (got_q.size() < count * 8) begin
                        @(posedge clk);
                        cycles++;
                        if (cycles > 400) begin
                                fail_run($sformatf("%s timed out waiting for %0d output vectors",
                                        test, count));
                        end
                end
                repeat (16) @(posedge clk);     // room for any stray extra vector
                @(negedge clk);
        endtask

        task automatic compare_results(input string test);
                check_count(test, expect_q.size() / 8, got_q.size() / 8);
                for (int i = 0; i < expect_q.size(); i++) begin
                        check_sample(test, expect_q[i], got_q[i]);
                end
                expect_q.delete();
                got_q.delete();
        endtask

        task automatic dc_block();
                clear_block();
                blk[0][0] = sample_t'(64);
                send_block(0);
                wait_vectors("dc_block", 8);
                check_count("dc_block", 8, got_q.size() / 8);
                for (int i = 0; i < got_q.size(); i++) begin
                        check_sample("dc_block", sample_t'(1), got_q[i]);
                end
                compare_results("dc_block");
        endtask

        task automatic impulse_blocks();
                int value;
                for (int p = 0; p < 64; p++) begin
                        clear_block();
                        value = 37 + p * 61;
                        if (p % 2 == 1) begin
                                value = -value;         // odd positions negative
                        end
                        blk[p / 8][p % 8] = sample_t'(value);
                        send_block(0);
                end
                wait_vectors("impulse_blocks", 64 * 8);
                compare_results("impulse_blocks");
        endtask

        task automatic random_gapped();
                repeat (10) begin
                        random_block();
                        send_block(3);
                end
                wait_vectors("random_gapped", 80);
                compare_results("random_gapped");
        endtask

        task automatic back_to_back();
                repeat (4) begin
                        random_block();
                        send_block(0);
                end
                wait_vectors("back_to_back", 32);
                compare_results("back_to_back");
        endtask

        task automatic reset_midblock();
                random_block();
                send_rows(5, 0);        // partial block, never modelled
                reset = 1'b1;
                repeat (5) begin
                        @(negedge clk);
                        if (out_valid !== 1'b0) begin
                                fail_run("reset_midblock: out_valid was high during reset");
                        end
                end
                reset = 1'b0;
                repeat (30) begin
                        @(negedge clk);
                        if (out_valid !== 1'b0) begin
                                fail_run("reset_midblock: out_valid rose after reset");
                        end
                end
                check_count("reset_midblock", 0, got_q.size() / 8);
                random_block();
                send_block(1);
                wait_vectors("reset_midblock", 8);
                compare_results("reset_midblock");
        endtask

        initial begin
                reset = 1'b1;
                in_valid = 1'b0;
                for (int c = 0; c < 8; c++) begin
                        in_row[c] = '0;
                end
                repeat (5) @(negedge clk);
                reset = 1'b0;
                repeat (2) @(negedge clk);
                dc_block();
                impulse_blocks();
                random_gapped();
                back_to_back();
                reset_midblock();
                $display("TEST RESULT: PASS");
                $finish;
        end

endmodule
